//--- src/lpif_link_pkg.sv
package lpif_link_pkg;

  ////////////////////////////////////////
  // Link constants
  ////////////////////////////////////////

  // Persistent marker sent with every online word
  localparam logic [1:0] MARKER_VALUE = 2'b01;

  // Receive FIFO geometry, depth is a power of two
  localparam int unsigned RX_FIFO_DEPTH = 8;
  localparam int unsigned RX_PTR_W      = 3;

  ////////////////////////////////////////
  // Plain vector types
  ////////////////////////////////////////

  // Credit counts
  typedef logic [7:0] credit_t;

  // Online delay values, in clk_wr cycles
  typedef logic [15:0] delay_t;

  ////////////////////////////////////////
  // Structured types
  ////////////////////////////////////////

  // One LPIF flit, 75 bits, MSB first
  typedef struct packed {
    logic [3:0]  state;
    logic [1:0]  protid;
    logic [63:0] data;
    logic        dvalid;
    logic [1:0]  crc;
    logic        crc_valid;
    logic        valid;
  } flit_t;

  // One PHY word, 80 bits
  typedef struct packed {
    logic [1:0] marker;
    logic       strobe;
    logic       credit;  // One credit returned to the partner
    logic       push;    // Flit field holds a real flit
    flit_t      flit;
  } phy_word_t;

  // Debug status, same layout for tx and rx
  typedef struct packed {
    logic [7:0]  level;   // Credits held, or FIFO fill
    logic [15:0] count;   // Flits sent, or flits received
    logic [7:0]  errors;  // Saturating error count
  } debug_word_t;

endpackage

//--- src/ll_auto_sync.sv
`timescale 1ns/1ns

module ll_auto_sync (
  input  logic                  clk_wr,
  input  logic                  rst_n,
  input  logic                  tx_online,
  input  logic                  rx_online,
  input  lpif_link_pkg::delay_t delay_x_value,
  input  lpif_link_pkg::delay_t delay_z_value,
  output logic                  tx_online_delay,
  output logic                  rx_online_delay,
  output logic                  tx_strobe,
  output logic [1:0]            tx_marker
);

  import lpif_link_pkg::*;

  ////////////////////////////////////////
  // Online delay counters
  ////////////////////////////////////////

  // Index 0 is tx, index 1 is rx
  logic [1:0] online_in;
  delay_t     delay_val [2];
  delay_t     remain_q  [2];
  logic [1:0] seen_q;
  logic [1:0] online_q;

  assign online_in    = {rx_online, tx_online};
  assign delay_val[0] = delay_z_value;
  assign delay_val[1] = delay_x_value;

  // Count starts on the first edge that samples the input high
  // Zero delay raises the output on that same edge
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      seen_q   <= '0;
      online_q <= '0;
      for (int i = 0; i < 2; i++) begin
        remain_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!online_in[i]) begin
          // Input gone, drop at once and rearm
          seen_q[i]   <= 1'b0;
          online_q[i] <= 1'b0;
        end else if (!seen_q[i]) begin
          seen_q[i] <= 1'b1;
          if (delay_val[i] == '0) begin
            online_q[i] <= 1'b1;
          end else begin
            remain_q[i] <= delay_val[i] - delay_t'(1);
          end
        end else if (!online_q[i]) begin
          if (remain_q[i] == '0) begin
            online_q[i] <= 1'b1;
          end else begin
            remain_q[i] <= remain_q[i] - delay_t'(1);
          end
        end
      end
    end
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

  ////////////////////////////////////////
  // Persistent strobe and marker
  ////////////////////////////////////////

  // Only valid while tx is online, zero otherwise
  assign tx_strobe = online_q[0];
  assign tx_marker = online_q[0] ? MARKER_VALUE : 2'b00;

endmodule

//--- src/lpif_flit_pack.sv
`timescale 1ns/1ns

module lpif_flit_pack (
  input  logic                 clk_wr,
  input  logic                 rst_n,
  // Upstream fields from the user
  input  logic [3:0]           ustrm_state,
  input  logic [1:0]           ustrm_protid,
  input  logic [63:0]          ustrm_data,
  input  logic                 ustrm_dvalid,
  input  logic [1:0]           ustrm_crc,
  input  logic                 ustrm_crc_valid,
  input  logic                 ustrm_valid,
  output lpif_link_pkg::flit_t tx_flit,
  // Flit leaving the receive FIFO
  input  lpif_link_pkg::flit_t pop_flit,
  input  logic                 pop_valid,
  // Downstream fields to the user
  output logic [3:0]           dstrm_state,
  output logic [1:0]           dstrm_protid,
  output logic [63:0]          dstrm_data,
  output logic                 dstrm_dvalid,
  output logic [1:0]           dstrm_crc,
  output logic                 dstrm_crc_valid,
  output logic                 dstrm_valid
);

  // Upstream pack, purely combinational
  assign tx_flit.state     = ustrm_state;
  assign tx_flit.protid    = ustrm_protid;
  assign tx_flit.data      = ustrm_data;
  assign tx_flit.dvalid    = ustrm_dvalid;
  assign tx_flit.crc       = ustrm_crc;
  assign tx_flit.crc_valid = ustrm_crc_valid;
  assign tx_flit.valid     = ustrm_valid;

  ////////////////////////////////////////
  // Downstream unpack
  ////////////////////////////////////////

  // Qualifier bits, low in any cycle without a pop
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      dstrm_valid     <= 1'b0;
      dstrm_dvalid    <= 1'b0;
      dstrm_crc_valid <= 1'b0;
    end else begin
      dstrm_valid     <= pop_valid & pop_flit.valid;
      dstrm_dvalid    <= pop_valid & pop_flit.dvalid;
      dstrm_crc_valid <= pop_valid & pop_flit.crc_valid;
    end
  end

  // Payload holds its last value between pops
  always_ff @(posedge clk_wr) begin
    if (pop_valid) begin
      dstrm_state  <= pop_flit.state;
      dstrm_protid <= pop_flit.protid;
      dstrm_data   <= pop_flit.data;
      dstrm_crc    <= pop_flit.crc;
    end
  end

endmodule

//--- src/ll_tx_credit_gate.sv
`timescale 1ns/1ns

module ll_tx_credit_gate (
  input  logic                       clk_wr,
  input  logic                       rst_n,
  input  logic                       tx_online_delay,
  input  lpif_link_pkg::credit_t     init_upstream_credit,
  input  logic                       ustrm_valid,
  input  logic                       credit_in,
  output logic                       ustrm_ready,
  output logic                       take,
  output lpif_link_pkg::debug_word_t tx_upstream_debug_status
);

  import lpif_link_pkg::*;

  credit_t     credit_q;
  logic [15:0] sent_q;
  logic [7:0]  err_q;
  logic        overflow;

  ////////////////////////////////////////
  // Credit gate
  ////////////////////////////////////////

  // Ready only with a credit in hand and the link up
  assign ustrm_ready = tx_online_delay & (credit_q != '0);
  assign take        = ustrm_valid & ustrm_ready;

  // Returned credit while none is outstanding
  assign overflow = credit_in & ~take & (credit_q == init_upstream_credit);

  // Preloaded while offline, so the full grant is there
  // on the very cycle tx_online_delay rises
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      credit_q <= '0;
    end else if (!tx_online_delay) begin
      credit_q <= init_upstream_credit;
    end else if (!overflow) begin
      // Take and return in one cycle cancel out
      credit_q <= credit_q + credit_t'(credit_in) - credit_t'(take);
    end
  end

  ////////////////////////////////////////
  // Debug counters
  ////////////////////////////////////////

  // Flits sent wraps, errors saturate
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      sent_q <= '0;
      err_q  <= '0;
    end else begin
      if (take) begin
        sent_q <= sent_q + 16'd1;
      end
      if (overflow && (err_q != '1)) begin
        err_q <= err_q + 8'd1;
      end
    end
  end

  assign tx_upstream_debug_status.level  = credit_q;
  assign tx_upstream_debug_status.count  = sent_q;
  assign tx_upstream_debug_status.errors = err_q;

endmodule

//--- src/ll_rx_credit_fifo.sv
`timescale 1ns/1ns

module ll_rx_credit_fifo (
  input  logic                       clk_wr,
  input  logic                       rst_n,
  input  lpif_link_pkg::flit_t       rx_flit,
  input  logic                       rx_push,
  input  logic                       rx_drop,
  input  logic                       dstrm_hold,
  output lpif_link_pkg::flit_t       pop_flit,
  output logic                       pop_valid,
  output logic                       credit_return,
  output lpif_link_pkg::debug_word_t rx_downstream_debug_status
);

  import lpif_link_pkg::*;

  flit_t               mem [RX_FIFO_DEPTH];
  logic [RX_PTR_W-1:0] wr_ptr;
  logic [RX_PTR_W-1:0] rd_ptr;
  logic [RX_PTR_W:0]   fill;
  logic                full;
  logic                wr_en;
  logic                rd_en;
  logic                overrun;
  logic [15:0]         rcv_cnt;
  logic [7:0]          err_cnt;

  ////////////////////////////////////////
  // FIFO control
  ////////////////////////////////////////

  assign full    = (fill == (RX_PTR_W + 1)'(RX_FIFO_DEPTH));
  assign wr_en   = rx_push & ~full;
  assign overrun = rx_push & full;
  // Drain whenever something is stored and the consumer allows it
  assign rd_en   = (fill != '0) & ~dstrm_hold;

  // Pointers wrap on their own, depth is 2**RX_PTR_W
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fill <= fill + (RX_PTR_W + 1)'(wr_en) - (RX_PTR_W + 1)'(rd_en);
    end
  end

  // Storage array
  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_ptr] <= rx_flit;
    end
  end

  assign pop_flit  = mem[rd_ptr];
  assign pop_valid = rd_en;

  // One credit back to the partner per popped flit
  assign credit_return = rd_en;

  ////////////////////////////////////////
  // Debug counters
  ////////////////////////////////////////

  // Overrun needs an accepted word, rx_drop a rejected one,
  // so at most one error per cycle
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rcv_cnt <= '0;
      err_cnt <= '0;
    end else begin
      if (wr_en) begin
        rcv_cnt <= rcv_cnt + 16'd1;
      end
      if ((overrun || rx_drop) && (err_cnt != '1)) begin
        err_cnt <= err_cnt + 8'd1;
      end
    end
  end

  assign rx_downstream_debug_status.level  = 8'(fill);
  assign rx_downstream_debug_status.count  = rcv_cnt;
  assign rx_downstream_debug_status.errors = err_cnt;

endmodule

//--- src/phy_word_concat.sv
`timescale 1ns/1ns

module phy_word_concat (
  input  logic                     clk_wr,
  input  logic                     rst_n,
  // Transmit side
  input  lpif_link_pkg::flit_t     tx_flit,
  input  logic                     take,
  input  logic                     credit_return,
  input  logic                     tx_strobe,
  input  logic [1:0]               tx_marker,
  input  logic                     rx_online_delay,
  output lpif_link_pkg::phy_word_t tx_phy0,
  // Receive side
  input  lpif_link_pkg::phy_word_t rx_phy0,
  output lpif_link_pkg::flit_t     rx_flit,
  output logic                     rx_push,
  output logic                     rx_drop,
  output logic                     credit_in
);

  import lpif_link_pkg::*;

  logic [1:0] marker_q;
  logic       strobe_q;
  logic       credit_q;
  logic       push_q;
  flit_t      flit_q;
  logic       accept;

  ////////////////////////////////////////
  // Transmit word
  ////////////////////////////////////////

  // Framing bits
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      marker_q <= '0;
      strobe_q <= 1'b0;
      credit_q <= 1'b0;
      push_q   <= 1'b0;
    end else begin
      marker_q <= tx_marker;
      strobe_q <= tx_strobe;
      credit_q <= credit_return;
      push_q   <= take;
    end
  end

  // Flit rides along, meaningful only with push set
  always_ff @(posedge clk_wr) begin
    flit_q <= tx_flit;
  end

  assign tx_phy0.marker = marker_q;
  assign tx_phy0.strobe = strobe_q;
  assign tx_phy0.credit = credit_q;
  assign tx_phy0.push   = push_q;
  assign tx_phy0.flit   = flit_q;

  ////////////////////////////////////////
  // Receive word check and split
  ////////////////////////////////////////

  // Strobe and marker must match, and the link must be up
  assign accept = rx_phy0.strobe & (rx_phy0.marker == MARKER_VALUE) & rx_online_delay;

  assign rx_flit   = rx_phy0.flit;
  assign rx_push   = accept & rx_phy0.push;
  assign credit_in = accept & rx_phy0.credit;
  // Rejected word that carried something
  assign rx_drop   = ~accept & (rx_phy0.push | rx_phy0.credit);

endmodule

//--- src/lpif_slave_top.sv
`timescale 1ns/1ns

module lpif_slave_top (
  input  logic                       clk_wr,
  input  logic                       rst_n,
  // Control and configuration
  input  logic                       tx_online,
  input  logic                       rx_online,
  input  lpif_link_pkg::credit_t     init_upstream_credit,
  input  lpif_link_pkg::delay_t      delay_x_value,
  input  lpif_link_pkg::delay_t      delay_z_value,
  // PHY words
  output lpif_link_pkg::phy_word_t   tx_phy0,
  input  lpif_link_pkg::phy_word_t   rx_phy0,
  // Downstream channel
  output logic [3:0]                 dstrm_state,
  output logic [1:0]                 dstrm_protid,
  output logic [63:0]                dstrm_data,
  output logic                       dstrm_dvalid,
  output logic [1:0]                 dstrm_crc,
  output logic                       dstrm_crc_valid,
  output logic                       dstrm_valid,
  input  logic                       dstrm_hold,
  // Upstream channel
  input  logic [3:0]                 ustrm_state,
  input  logic [1:0]                 ustrm_protid,
  input  logic [63:0]                ustrm_data,
  input  logic                       ustrm_dvalid,
  input  logic [1:0]                 ustrm_crc,
  input  logic                       ustrm_crc_valid,
  input  logic                       ustrm_valid,
  output logic                       ustrm_ready,
  // Debug status
  output lpif_link_pkg::debug_word_t rx_downstream_debug_status,
  output lpif_link_pkg::debug_word_t tx_upstream_debug_status
);

  import lpif_link_pkg::*;

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////

  logic       tx_online_delay;
  logic       rx_online_delay;
  logic       tx_strobe;
  logic [1:0] tx_marker;
  flit_t      tx_flit;
  logic       take;
  flit_t      rx_flit;
  logic       rx_push;
  logic       rx_drop;
  logic       credit_in;
  flit_t      pop_flit;
  logic       pop_valid;
  logic       credit_return;

  // Online delays and framing bits
  ll_auto_sync u_auto_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_strobe       (tx_strobe),
    .tx_marker       (tx_marker)
  );

  // User side flit pack and unpack
  lpif_flit_pack u_flit_pack (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_flit         (tx_flit),
    .pop_flit        (pop_flit),
    .pop_valid       (pop_valid),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

  ll_tx_credit_gate u_tx_credit_gate (
    .clk_wr                   (clk_wr),
    .rst_n                    (rst_n),
    .tx_online_delay          (tx_online_delay),
    .init_upstream_credit     (init_upstream_credit),
    .ustrm_valid              (ustrm_valid),
    .credit_in                (credit_in),
    .ustrm_ready              (ustrm_ready),
    .take                     (take),
    .tx_upstream_debug_status (tx_upstream_debug_status)
  );

  ll_rx_credit_fifo u_rx_credit_fifo (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .rx_flit                    (rx_flit),
    .rx_push                    (rx_push),
    .rx_drop                    (rx_drop),
    .dstrm_hold                 (dstrm_hold),
    .pop_flit                   (pop_flit),
    .pop_valid                  (pop_valid),
    .credit_return              (credit_return),
    .rx_downstream_debug_status (rx_downstream_debug_status)
  );

  // PHY word framing
  phy_word_concat u_phy_word_concat (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_flit         (tx_flit),
    .take            (take),
    .credit_return   (credit_return),
    .tx_strobe       (tx_strobe),
    .tx_marker       (tx_marker),
    .rx_online_delay (rx_online_delay),
    .tx_phy0         (tx_phy0),
    .rx_phy0         (rx_phy0),
    .rx_flit         (rx_flit),
    .rx_push         (rx_push),
    .rx_drop         (rx_drop),
    .credit_in       (credit_in)
  );

endmodule

//--- dv/lpif_slave_tb.sv
`timescale 1ns/1ns

module lpif_slave_tb;

  import lpif_link_pkg::*;

  ////////////////////////////////////////
  // Configuration and limits
  ////////////////////////////////////////

  localparam credit_t INIT_CREDIT     = 8'd8;
  localparam delay_t  DELAY_X         = 16'd4;
  localparam delay_t  DELAY_Z         = 16'd6;
  localparam int      STREAM_FLITS    = 20;
  localparam int      RESUME_FLITS    = 4;
  localparam int      TOTAL_FLITS     = STREAM_FLITS + int'(INIT_CREDIT) + RESUME_FLITS;
  localparam int      WATCHDOG_CYCLES = TOTAL_FLITS * 20 + 400;
  // Bound on any single wait inside a test
  localparam int      WAIT_LIMIT      = 200;

  logic        clk_wr;
  logic        rst_n;
  logic        tx_online;
  logic        rx_online;
  credit_t     init_upstream_credit;
  delay_t      delay_x_value;
  delay_t      delay_z_value;
  phy_word_t   phy_loop;
  logic [3:0]  ustrm_state;
  logic [1:0]  ustrm_protid;
  logic [63:0] ustrm_data;
  logic        ustrm_dvalid;
  logic [1:0]  ustrm_crc;
  logic        ustrm_crc_valid;
  logic        ustrm_valid;
  logic        ustrm_ready;
  logic [3:0]  dstrm_state;
  logic [1:0]  dstrm_protid;
  logic [63:0] dstrm_data;
  logic        dstrm_dvalid;
  logic [1:0]  dstrm_crc;
  logic        dstrm_crc_valid;
  logic        dstrm_valid;
  logic        dstrm_hold;
  debug_word_t rx_dbg;
  debug_word_t tx_dbg;

  // Scoreboard and bookkeeping
  logic [15:0] lfsr_state;
  flit_t       sb_q [$];
  int          n_taken;
  int          n_out;
  int          flit_errors;
  int          value_errors;
  int          monitor_errors;
  int          other_errors;
  // Set while no downstream flit may show up
  logic        quiet;

  // tx_phy0 fed straight back into rx_phy0
  lpif_slave_top uut (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .init_upstream_credit       (init_upstream_credit),
    .delay_x_value              (delay_x_value),
    .delay_z_value              (delay_z_value),
    .tx_phy0                    (phy_loop),
    .rx_phy0                    (phy_loop),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .dstrm_hold                 (dstrm_hold),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .ustrm_ready                (ustrm_ready),
    .rx_downstream_debug_status (rx_dbg),
    .tx_upstream_debug_status   (tx_dbg)
  );

  initial begin
    clk_wr = 1'b0;
    forever #2 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////
  // Random source and compare tasks
  ////////////////////////////////////////

  // 16-bit Galois LFSR shifting right with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  // One LFSR step per bit
  task automatic rand_bits(input int width, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < width; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v[i] = lfsr_state[0];
    end
  endtask

  task automatic check_flit(input string name, input flit_t got, input flit_t exp);
    if (got !== exp) begin
      flit_errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_debug(input string name, input debug_word_t got,
                             input debug_word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic expect_count(input string what, input int got, input int exp);
    if (got != exp) begin
      other_errors++;
      $display("At %0t %s came to %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Monitor and scoreboard
  ////////////////////////////////////////

  // Sampled at the negedge where everything is stable
  always @(negedge clk_wr) begin : monitor
    flit_t exp_flit;
    flit_t got_flit;
    if (rst_n) begin
      // Valid and ready now means a take at the next edge
      if (ustrm_valid && ustrm_ready) begin
        exp_flit.state     = ustrm_state;
        exp_flit.protid    = ustrm_protid;
        exp_flit.data      = ustrm_data;
        exp_flit.dvalid    = ustrm_dvalid;
        exp_flit.crc       = ustrm_crc;
        exp_flit.crc_valid = ustrm_crc_valid;
        exp_flit.valid     = 1'b1;
        sb_q.push_back(exp_flit);
        n_taken++;
      end
      if (dstrm_valid) begin
        got_flit.state     = dstrm_state;
        got_flit.protid    = dstrm_protid;
        got_flit.data      = dstrm_data;
        got_flit.dvalid    = dstrm_dvalid;
        got_flit.crc       = dstrm_crc;
        got_flit.crc_valid = dstrm_crc_valid;
        got_flit.valid     = dstrm_valid;
        if (quiet) begin
          monitor_errors++;
          $display("Downstream flit at %0t while the channel should be idle", $time);
        end
        if (sb_q.size() == 0) begin
          monitor_errors++;
          $display("Downstream flit at %0t with no flit outstanding", $time);
        end else begin
          exp_flit = sb_q.pop_front();
          check_flit("dstrm flit", got_flit, exp_flit);
        end
        n_out++;
      end else begin
        // Qualifiers cleared in any cycle without a flit
        check_bit("dstrm_dvalid", dstrm_dvalid, 1'b0);
        check_bit("dstrm_crc_valid", dstrm_crc_valid, 1'b0);
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic load_random_fields();
    logic [63:0] bits;
    rand_bits(4, bits);
    ustrm_state <= bits[3:0];
    rand_bits(2, bits);
    ustrm_protid <= bits[1:0];
    rand_bits(64, bits);
    ustrm_data <= bits;
    rand_bits(1, bits);
    ustrm_dvalid <= bits[0];
    rand_bits(2, bits);
    ustrm_crc <= bits[1:0];
    rand_bits(1, bits);
    ustrm_crc_valid <= bits[0];
  endtask

  // Returns at a negedge where ready is high, or on timeout
  task automatic wait_for_ready(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk_wr);
    while (!ustrm_ready && cycles < WAIT_LIMIT) begin
      @(negedge clk_wr);
      cycles++;
    end
    if (!ustrm_ready) begin
      other_errors++;
      $display("Timed out at %0t waiting for ustrm_ready in %s", $time, what);
    end
  endtask

  task automatic send_flit(input string what);
    @(posedge clk_wr);
    load_random_fields();
    ustrm_valid <= 1'b1;
    wait_for_ready(what);
    // Taken on this edge
    @(posedge clk_wr);
    ustrm_valid <= 1'b0;
  endtask

  // All credits home and FIFO empty, so every taken flit has been shown
  task automatic wait_drained(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk_wr);
    while ((tx_dbg.level != INIT_CREDIT || rx_dbg.level != 8'd0) && cycles < WAIT_LIMIT) begin
      @(negedge clk_wr);
      cycles++;
    end
    if (tx_dbg.level != INIT_CREDIT || rx_dbg.level != 8'd0) begin
      other_errors++;
      $display("Timed out at %0t waiting for the link to drain in %s", $time, what);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_reset_online();
    int low_cycles;
    @(negedge clk_wr);
    check_bit("ustrm_ready", ustrm_ready, 1'b0);
    check_bit("dstrm_valid", dstrm_valid, 1'b0);
    check_bit("tx_phy0.push", phy_loop.push, 1'b0);
    check_bit("tx_phy0.credit", phy_loop.credit, 1'b0);
    check_bit("tx_phy0.strobe", phy_loop.strobe, 1'b0);
    check_bit("tx_phy0.marker nonzero", |phy_loop.marker, 1'b0);
    @(posedge clk_wr);
    tx_online <= 1'b1;
    rx_online <= 1'b1;
    // First edge that samples tx_online high
    @(posedge clk_wr);
    low_cycles = 0;
    @(negedge clk_wr);
    while (!ustrm_ready && low_cycles < WAIT_LIMIT) begin
      low_cycles++;
      @(negedge clk_wr);
    end
    expect_count("cycles of ustrm_ready low after tx_online", low_cycles, int'(DELAY_Z));
    // Framing bits one cycle behind tx_online_delay
    @(negedge clk_wr);
    check_bit("tx_phy0.strobe", phy_loop.strobe, 1'b1);
    check_bit("tx_phy0.marker matches", phy_loop.marker == MARKER_VALUE, 1'b1);
  endtask

  task automatic test_stream_order();
    int out_before;
    logic [63:0] gap;
    @(posedge clk_wr);
    out_before = n_out;
    for (int i = 0; i < STREAM_FLITS; i++) begin
      send_flit("stream order");
      rand_bits(2, gap);
      repeat (int'(gap[1:0])) @(posedge clk_wr);
    end
    wait_drained("stream order");
    @(posedge clk_wr);
    expect_count("stream order flits out", n_out - out_before, STREAM_FLITS);
    expect_count("stream order flits left over", sb_q.size(), 0);
  endtask

  task automatic test_credit_backpressure();
    int out_before;
    int takes;
    @(posedge clk_wr);
    out_before = n_out;
    dstrm_hold <= 1'b1;
    quiet <= 1'b1;
    load_random_fields();
    ustrm_valid <= 1'b1;
    takes = 0;
    // Ready at a negedge means a take at the next edge
    @(negedge clk_wr);
    while (ustrm_ready && takes < WAIT_LIMIT) begin
      @(posedge clk_wr);
      load_random_fields();
      takes++;
      @(negedge clk_wr);
    end
    expect_count("flits taken before ustrm_ready fell", takes, int'(INIT_CREDIT));
    // Nothing moves while held
    repeat (10) @(negedge clk_wr);
    check_bit("ustrm_ready under hold", ustrm_ready, 1'b0);
    @(posedge clk_wr);
    ustrm_valid <= 1'b0;
    dstrm_hold <= 1'b0;
    quiet <= 1'b0;
    wait_drained("credit backpressure");
    check_bit("ustrm_ready after release", ustrm_ready, 1'b1);
    @(posedge clk_wr);
    expect_count("backpressure flits out", n_out - out_before, int'(INIT_CREDIT));
    expect_count("backpressure flits left over", sb_q.size(), 0);
  endtask

  task automatic test_debug_status();
    debug_word_t exp_tx;
    debug_word_t exp_rx;
    repeat (4) @(posedge clk_wr);
    exp_tx.level  = INIT_CREDIT;
    exp_tx.count  = 16'(n_taken);
    exp_tx.errors = 8'd0;
    exp_rx.level  = 8'd0;
    exp_rx.count  = 16'(n_taken);
    exp_rx.errors = 8'd0;
    @(negedge clk_wr);
    check_debug("tx_upstream_debug_status", tx_dbg, exp_tx);
    check_debug("rx_downstream_debug_status", rx_dbg, exp_rx);
  endtask

  task automatic test_rx_offline();
    int out_before;
    debug_word_t exp_rx;
    wait_drained("rx offline entry");
    @(posedge clk_wr);
    out_before = n_out;
    rx_online <= 1'b0;
    quiet <= 1'b1;
    repeat (12) @(posedge clk_wr);
    rx_online <= 1'b1;
    // Rx online delay plus margin with no flit expected
    repeat (int'(DELAY_X) + 8) @(posedge clk_wr);
    quiet <= 1'b0;
    for (int i = 0; i < RESUME_FLITS; i++) begin
      send_flit("rx offline resume");
    end
    wait_drained("rx offline resume");
    @(posedge clk_wr);
    expect_count("flits out after rx resume", n_out - out_before, RESUME_FLITS);
    expect_count("flits left over after rx resume", sb_q.size(), 0);
    exp_rx.level  = 8'd0;
    exp_rx.count  = 16'(n_taken);
    exp_rx.errors = 8'd0;
    @(negedge clk_wr);
    check_debug("rx_downstream_debug_status", rx_dbg, exp_rx);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    rst_n                = 1'b0;
    tx_online            = 1'b0;
    rx_online            = 1'b0;
    init_upstream_credit = INIT_CREDIT;
    delay_x_value        = DELAY_X;
    delay_z_value        = DELAY_Z;
    dstrm_hold           = 1'b0;
    ustrm_state          = '0;
    ustrm_protid         = '0;
    ustrm_data           = '0;
    ustrm_dvalid         = 1'b0;
    ustrm_crc            = '0;
    ustrm_crc_valid      = 1'b0;
    ustrm_valid          = 1'b0;
    quiet                = 1'b0;
    lfsr_state           = 16'd25851;
    n_taken              = 0;
    n_out                = 0;
    flit_errors          = 0;
    value_errors         = 0;
    monitor_errors       = 0;
    other_errors         = 0;
    repeat (5) @(posedge clk_wr);
    rst_n <= 1'b1;
    test_reset_online();
    test_stream_order();
    test_credit_backpressure();
    test_debug_status();
    test_rx_offline();
    repeat (5) @(posedge clk_wr);
    $display("Errors: %0d flit, %0d value, %0d monitor, %0d other",
             flit_errors, value_errors, monitor_errors, other_errors);
    if (flit_errors + value_errors + monitor_errors + other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_wr);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Errors: %0d flit, %0d value, %0d monitor, %0d other",
             flit_errors, value_errors, monitor_errors, other_errors);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- sources.f
src/lpif_link_pkg.sv
src/ll_auto_sync.sv
src/lpif_flit_pack.sv
src/ll_tx_credit_gate.sv
src/ll_rx_credit_fifo.sv
src/phy_word_concat.sv
src/lpif_slave_top.sv
dv/lpif_slave_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the LPIF slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module lpif_slave_tb \
  -Mdir obj_dir -o lpif_slave_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/lpif_slave_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
  exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
